//--- sources.f
+incdir+design
design/decoderPkg.sv
design/stackCallDecoder.sv
design/indexLoadDecoder.sv
design/groupCombiner.sv
design/stepSequencer.sv
design/opGroupDecoder.sv
verification/opGroupDecoderTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build the decoder testbench with Verilator, run it, and judge the log
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --timescale 1ns/1ps -f sources.f \
    --top-module opGroupDecoderTb --Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simv > "$LOG" 2>&1
simStatus=$?
cat "$LOG"

if grep -q "TESTBENCH FAILED" "$LOG"; then
    echo "Simulation reported a failure"
    exit 1
fi

if [ "$simStatus" -ne 0 ]; then
    echo "Simulator exited with status $simStatus"
    exit 1
fi

echo "Simulation completed without reported failure"
exit 0

//--- verification/opGroupDecoderTb.sv
// Random-stimulus testbench for opGroupDecoder that checks ctl every cycle against a cycle model
`timescale 1ns/1ps

module opGroupDecoderTb;

    logic                    clk;
    logic                    rst;
    logic                    opStrobe;
    decoderPkg::opcode_t     opcode;
    decoderPkg::controlBus_t ctl;

    logic [31:0]         seed;
    int                  instrCount;
    logic                mActive; // Model sequencer state
    decoderPkg::opcode_t mItable;
    int                  mStep;

    opGroupDecoder opGroupDecoder_inst (
        .clk      (clk),
        .rst      (rst),
        .opStrobe (opStrobe),
        .opcode   (opcode),
        .ctl      (ctl)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    function automatic logic [31:0] lcgNext();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return {16'h0000, seed[31:16]}; // Upper half since the low bits are weak
    endfunction

    function automatic int randBelow(input int n);
        return int'(lcgNext() % n);
    endfunction

    function automatic decoderPkg::opcode_t randomByte();
        logic [31:0] r;
        r = lcgNext();
        return r[7:0];
    endfunction

    // Half group hits, a quarter near misses, the rest anything
    function automatic decoderPkg::opcode_t pickOpcode();
        int bucket;
        int pick;
        decoderPkg::opcode_t op;
        bucket = randBelow(4);
        if (bucket < 2) begin
            pick = randBelow(3);
            op = (pick == 0) ? 8'h1D : ((pick == 1) ? 8'h1B : 8'h1F);
        end else if (bucket == 2) begin
            pick = randBelow(5);
            case (pick)
                0: op = 8'h18;
                1: op = 8'h1A;
                2: op = 8'h1C;
                3: op = 8'h1E;
                default: op = 8'h19;
            endcase
        end else begin
            op = randomByte();
        end
        return op;
    endfunction

    // Expected ctl from the model state and the per-step table
    function automatic decoderPkg::controlBus_t expectedCtl();
        decoderPkg::controlBus_t e;
        logic isCall;
        logic isLoad;
        logic toIy;
        e = '0;
        if (!mActive) return e;
        isCall = (mItable == 8'h1D);
        isLoad = (mItable == 8'h1B) || (mItable == 8'h1F);
        toIy = (mItable == 8'h1F);
        if (isCall) begin
            if (mStep == 0 || mStep == 1) begin
                e.decSp = 1'b1;
                e.selectAdSp = 1'b1;
                e.memWrite = 1'b1;
                e.selectDtPcHigh = (mStep == 0);
                e.selectDtPcLow = (mStep == 1);
            end else if (mStep == 2) begin
                e.selectOpOld = 1'b1;
                e.writePcLow = 1'b1;
                e.writePcHigh = 1'b1;
                e.endOfInstruction = 1'b1;
            end
        end else if (isLoad) begin
            if (mStep == 0 || mStep == 1) begin
                e.selectAdOpOld = 1'b1;
                e.memRead = 1'b1;
                e.selectAdNext = (mStep == 1);
                e.writeIxLow = (mStep == 1) && !toIy;
                e.writeIyLow = (mStep == 1) && toIy;
            end else if (mStep == 2) begin
                e.writeIxHigh = !toIy;
                e.writeIyHigh = toIy;
                e.endOfInstruction = 1'b1;
            end
        end else begin
            e.nop = 1'b1;
            e.endOfInstruction = 1'b1;
        end
        return e;
    endfunction

    // Model update on each clock edge with the strobe taking priority
    task automatic nextEdge();
        decoderPkg::controlBus_t prev;
        @(posedge clk);
        prev = expectedCtl();
        if (opStrobe) begin
            mActive = 1'b1;
            mItable = opcode;
            mStep = 0;
        end else if (mActive) begin
            if (prev.endOfInstruction) begin
                mActive = 1'b0;
                mStep = 0;
            end else begin
                mStep = mStep + 1;
            end
        end
    endtask

    task automatic compareField(input string name, input logic got, input logic want);
        assert (got === want) else begin
            $display("MISMATCH at time %0t: field %s expected %0b got %0b", $time, name,
                want, got);
            $display("TESTBENCH FAILED");
            $fatal(1, "Stopped at first output error");
        end
    endtask

    task automatic checkCtl();
        decoderPkg::controlBus_t want;
        want = expectedCtl();
        compareField("decSp", ctl.decSp, want.decSp);
        compareField("selectAdSp", ctl.selectAdSp, want.selectAdSp);
        compareField("selectDtPcHigh", ctl.selectDtPcHigh, want.selectDtPcHigh);
        compareField("selectDtPcLow", ctl.selectDtPcLow, want.selectDtPcLow);
        compareField("memWrite", ctl.memWrite, want.memWrite);
        compareField("memRead", ctl.memRead, want.memRead);
        compareField("selectAdOpOld", ctl.selectAdOpOld, want.selectAdOpOld);
        compareField("selectAdNext", ctl.selectAdNext, want.selectAdNext);
        compareField("selectOpOld", ctl.selectOpOld, want.selectOpOld);
        compareField("writePcLow", ctl.writePcLow, want.writePcLow);
        compareField("writePcHigh", ctl.writePcHigh, want.writePcHigh);
        compareField("writeIxLow", ctl.writeIxLow, want.writeIxLow);
        compareField("writeIxHigh", ctl.writeIxHigh, want.writeIxHigh);
        compareField("writeIyLow", ctl.writeIyLow, want.writeIyLow);
        compareField("writeIyHigh", ctl.writeIyHigh, want.writeIyHigh);
        compareField("nop", ctl.nop, want.nop);
        compareField("endOfInstruction", ctl.endOfInstruction, want.endOfInstruction);
    endtask

    // Drive on the rising edge and check at the falling edge
    task automatic driveAndCheck(input logic strobe, input decoderPkg::opcode_t op);
        opStrobe <= strobe;
        opcode <= op;
        @(negedge clk);
        checkCtl();
    endtask

    task automatic runInstruction();
        decoderPkg::opcode_t op;
        decoderPkg::controlBus_t upcoming;
        int cycles;
        int restartAt; // 0 or 1 mid-sequence, 3 in the end cycle, -1 never
        int r;
        logic strobeNow;
        logic finished;
        if (randBelow(4) == 0) begin
            nextEdge();
            driveAndCheck(1'b0, randomByte()); // Opcode ignored without a strobe
        end
        op = pickOpcode();
        nextEdge();
        driveAndCheck(1'b1, op);
        instrCount++;
        r = randBelow(8);
        restartAt = (r < 2) ? r : ((r == 2) ? 3 : -1);
        cycles = 0;
        finished = 1'b0;
        while (!finished) begin
            if (cycles == 16) begin
                $display("ERROR: end of instruction never came within 16 cycles");
                $display("TESTBENCH FAILED");
                $fatal(1, "Timeout waiting for end of instruction");
            end
            nextEdge();
            upcoming = expectedCtl();
            strobeNow = (restartAt == cycles) ||
                (restartAt == 3 && upcoming.endOfInstruction);
            if (strobeNow) begin
                restartAt = -1;
                op = pickOpcode();
                instrCount++;
                driveAndCheck(1'b1, op);
            end else begin
                driveAndCheck(1'b0, randomByte());
            end
            if (ctl.endOfInstruction && !strobeNow) finished = 1'b1;
            cycles++;
        end
    endtask

    initial begin
        rst <= 1'b1;
        opStrobe <= 1'b0;
        opcode <= '0;
        seed = 32'hefed;
        instrCount = 0;
        mActive = 1'b0;
        mItable = '0;
        mStep = 0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        repeat (3) begin
            nextEdge();
            driveAndCheck(1'b0, randomByte()); // All zero before any strobe
        end
        while (instrCount < 400) begin
            runInstruction();
        end
        repeat (2) begin
            nextEdge();
            driveAndCheck(1'b0, randomByte());
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

//--- design/opGroupDecoder.sv
// Top level of the 00011xx1 decoder slice that wires the sequencer, both decoders and the combiner
`timescale 1ns/1ps

module opGroupDecoder (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    opStrobe,
    input  decoderPkg::opcode_t     opcode,
    output decoderPkg::controlBus_t ctl
);

    decoderPkg::opcode_t   itable;
    decoderPkg::step_t     step;
    logic                  active;
    decoderPkg::stackCtl_t stackCtl;
    decoderPkg::indexCtl_t indexCtl;

    stepSequencer stepSequencer_inst (
        .clk              (clk),
        .rst              (rst),
        .opStrobe         (opStrobe),
        .opcode           (opcode),
        .endOfInstruction (ctl.endOfInstruction), // Fed back from combiner
        .itable           (itable),
        .step             (step),
        .active           (active)
    );

    stackCallDecoder stackCallDecoder_inst (
        .itable   (itable),
        .step     (step),
        .active   (active),
        .stackCtl (stackCtl)
    );

    indexLoadDecoder indexLoadDecoder_inst (
        .itable   (itable),
        .step     (step),
        .active   (active),
        .indexCtl (indexCtl)
    );

    groupCombiner groupCombiner_inst (
        .stackCtl (stackCtl),
        .indexCtl (indexCtl),
        .active   (active),
        .ctl      (ctl)
    );

endmodule

//--- design/stepSequencer.sv
// Instruction register, micro-step counter and IDLE/RUN FSM feeding both sequence decoders
`timescale 1ns/1ps
`include "decoder_cfg.svh"

module stepSequencer (
    input  logic                clk,
    input  logic                rst,
    input  logic                opStrobe,
    input  decoderPkg::opcode_t opcode,
    input  logic                endOfInstruction,
    output decoderPkg::opcode_t itable,
    output decoderPkg::step_t   step,
    output logic                active
);

    decoderPkg::seqState_t state;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= decoderPkg::IDLE;
            step  <= '0;
        end else if (opStrobe) begin
            state <= decoderPkg::RUN; // Strobe restarts even mid-sequence
            step  <= '0;
        end else if (state == decoderPkg::RUN) begin
            if (endOfInstruction) begin
                state <= decoderPkg::IDLE;
                step  <= '0;
            end else begin
                step <= step + `STEP_WIDTH'(1);
            end
        end
    end

    // ITABLE loaded on the strobe
    always_ff @(posedge clk) begin
        if (opStrobe) begin
            itable <= opcode;
        end
    end

    assign active = (state == decoderPkg::RUN);

endmodule

//--- design/groupCombiner.sv
// Merges the two sequence decoders into one control bus with end of instruction and NOP
`timescale 1ns/1ps

module groupCombiner (
    input  decoderPkg::stackCtl_t   stackCtl,
    input  decoderPkg::indexCtl_t   indexCtl,
    input  logic                    active,
    output decoderPkg::controlBus_t ctl
);

    logic nop;

    // Nobody claims the opcode, so it ends right here
    assign nop = active && !stackCtl.match && !indexCtl.match;

    always_comb begin
        ctl = '0;
        ctl.decSp          = stackCtl.decSp;
        ctl.selectAdSp     = stackCtl.selectAdSp;
        ctl.selectDtPcHigh = stackCtl.selectDtPcHigh;
        ctl.selectDtPcLow  = stackCtl.selectDtPcLow;
        ctl.memWrite       = stackCtl.memWrite;
        ctl.memRead        = indexCtl.memRead;
        ctl.selectAdOpOld  = indexCtl.selectAdOpOld;
        ctl.selectAdNext   = indexCtl.selectAdNext;
        ctl.selectOpOld    = stackCtl.selectOpOld;
        ctl.writePcLow     = stackCtl.writePcLow;
        ctl.writePcHigh    = stackCtl.writePcHigh;
        ctl.writeIxLow     = indexCtl.writeIxLow;
        ctl.writeIxHigh    = indexCtl.writeIxHigh;
        ctl.writeIyLow     = indexCtl.writeIyLow;
        ctl.writeIyHigh    = indexCtl.writeIyHigh;
        ctl.nop            = nop;
        // End of instruction from either sequence or a NOP
        ctl.endOfInstruction = stackCtl.lastStep | indexCtl.lastStep | nop;
    end

endmodule

//--- design/indexLoadDecoder.sv
// Per-step combinational decode of the 00011x11 IX/IY load, instantiated by opGroupDecoder
`timescale 1ns/1ps

module indexLoadDecoder (
    input  decoderPkg::opcode_t   itable,
    input  decoderPkg::step_t     step,
    input  logic                  active,
    output decoderPkg::indexCtl_t indexCtl
);

    logic match;
    logic useIy;

    assign match = active && (itable[7:3] == 5'b00011) && (itable[1:0] == 2'b11);
    assign useIy = itable[2]; // 0 selects IX, 1 selects IY

    always_comb begin
        indexCtl = '0;
        if (match) begin
            indexCtl.match = 1'b1;
            case (step)
                decoderPkg::step_t'(0): begin
                    indexCtl.selectAdOpOld = 1'b1; // Low byte at operand address
                    indexCtl.memRead       = 1'b1;
                end
                decoderPkg::step_t'(1): begin
                    // Latch low byte and fetch high byte at address plus one
                    indexCtl.selectAdOpOld = 1'b1;
                    indexCtl.selectAdNext  = 1'b1;
                    indexCtl.memRead       = 1'b1;
                    indexCtl.writeIxLow    = !useIy;
                    indexCtl.writeIyLow    = useIy;
                end
                decoderPkg::step_t'(2): begin
                    indexCtl.writeIxHigh = !useIy;
                    indexCtl.writeIyHigh = useIy;
                    indexCtl.lastStep    = 1'b1;
                end
                default: ;
            endcase
        end
    end

endmodule

//--- design/stackCallDecoder.sv
// Per-step combinational decode of the 00011101 stack call, instantiated by opGroupDecoder
`timescale 1ns/1ps

module stackCallDecoder (
    input  decoderPkg::opcode_t   itable,
    input  decoderPkg::step_t     step,
    input  logic                  active,
    output decoderPkg::stackCtl_t stackCtl
);

    logic match;

    assign match = active && (itable == 8'b0001_1101);

    always_comb begin
        stackCtl = '0;
        if (match) begin
            stackCtl.match = 1'b1;
            case (step)
                decoderPkg::step_t'(0): begin
                    // Push PC high through the decremented SP
                    stackCtl.decSp          = 1'b1;
                    stackCtl.selectAdSp     = 1'b1;
                    stackCtl.selectDtPcHigh = 1'b1;
                    stackCtl.memWrite       = 1'b1;
                end
                decoderPkg::step_t'(1): begin
                    stackCtl.decSp         = 1'b1;
                    stackCtl.selectAdSp    = 1'b1;
                    stackCtl.selectDtPcLow = 1'b1; // Then PC low
                    stackCtl.memWrite      = 1'b1;
                end
                decoderPkg::step_t'(2): begin
                    stackCtl.selectOpOld = 1'b1; // Jump target from operand latch
                    stackCtl.writePcLow  = 1'b1;
                    stackCtl.writePcHigh = 1'b1;
                    stackCtl.lastStep    = 1'b1;
                end
                default: ;
            endcase
        end
    end

endmodule

//--- design/decoderPkg.sv
// Shared opcode, step and control word types for the 00011xx1 decoder slice; compile first
`include "decoder_cfg.svh"

package decoderPkg;

    typedef logic [`OPCODE_WIDTH-1:0] opcode_t; // Latched instruction, ITABLE
    typedef logic [`STEP_WIDTH-1:0] step_t; // Micro-step, XPT

    typedef enum logic [0:0] {
        IDLE,
        RUN
    } seqState_t;

    // Stack-call decoder output, all zero unless match
    typedef struct packed {
        logic match;
        logic decSp;
        logic selectAdSp;
        logic selectDtPcHigh;
        logic selectDtPcLow;
        logic memWrite;
        logic selectOpOld;
        logic writePcLow;
        logic writePcHigh;
        logic lastStep;
    } stackCtl_t;

    // Index-load decoder output, all zero unless match
    typedef struct packed {
        logic match;
        logic selectAdOpOld;
        logic selectAdNext;
        logic memRead;
        logic writeIxLow;
        logic writeIxHigh;
        logic writeIyLow;
        logic writeIyHigh;
        logic lastStep;
    } indexCtl_t;

    // Merged strobes seen by the datapath
    typedef struct packed {
        logic decSp;
        logic selectAdSp;
        logic selectDtPcHigh;
        logic selectDtPcLow;
        logic memWrite;
        logic memRead;
        logic selectAdOpOld;
        logic selectAdNext;
        logic selectOpOld;
        logic writePcLow;
        logic writePcHigh;
        logic writeIxLow;
        logic writeIxHigh;
        logic writeIyLow;
        logic writeIyHigh;
        logic nop;
        logic endOfInstruction;
    } controlBus_t;

endpackage

//--- design/decoder_cfg.svh
// Width settings for the 00011xx1 decoder slice, included by the package and the sequencer
`ifndef DECODER_CFG_SVH
`define DECODER_CFG_SVH

// Instruction register (ITABLE) width
`define OPCODE_WIDTH 8

// Micro-step counter (XPT) width
`define STEP_WIDTH 4

`endif
